/* include/binning_params.svh */
`ifndef BINNING_PARAMS_SVH
`define BINNING_PARAMS_SVH

// --------------------
// pixel format
// --------------------

// bits per pixel
`define BIN_PIX_W 8

// --------------------
// line storage
// --------------------

// longest input line the line buffer can hold
`define BIN_LINE_MAX 1024

// line buffer address width
`define BIN_ADDR_W ($clog2(`BIN_LINE_MAX))

// cycles from the closing input beat to the output beat,
// same for the binned and the bypass path
`define BIN_LATENCY 4

`endif

/* hw/binning_pkg.sv */
`default_nettype none

`include "binning_params.svh"

package binning_pkg;

    // --------------------
    // stream beat
    // --------------------

    // one pixel of the valid-only video stream
    typedef struct packed {
        logic [`BIN_PIX_W-1:0] pix;
        logic                  de;
        logic                  sof;
        logic                  eol;
    } video_beat_t;

    // --------------------
    // 2x2 window
    // --------------------

    // top is the stored row, bottom the current row
    typedef struct packed {
        logic [`BIN_PIX_W-1:0] top_left;
        logic [`BIN_PIX_W-1:0] top_right;
        logic [`BIN_PIX_W-1:0] bot_left;
        logic [`BIN_PIX_W-1:0] bot_right;
        logic                  valid;
        logic                  sof;
        logic                  eol;
    } bin_window_t;

    // row state of the incoming frame
    typedef enum logic [1:0] {
        LINE_IDLE,
        LINE_EVEN,
        LINE_ODD
    } line_state_e;

endpackage

`default_nettype wire

/* hw/line_timing.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module line_timing import binning_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire video_beat_t       beat_i,
    output logic [`BIN_ADDR_W-1:0] buf_addr_o,
    output logic                   buf_we_o,
    output logic                   odd_row_o,
    output logic                   odd_col_o,
    output logic                   blk_sof_o,
    output logic                   blk_eol_o
);

    line_state_e            state_q;
    line_state_e            state_cur;
    logic [`BIN_ADDR_W-1:0] col_q;
    logic [`BIN_ADDR_W-1:0] col_cur;
    logic                   first_q;
    logic                   first_cur;
    logic                   start;

    // --------------------
    // position of the current beat
    // --------------------

    // sof restarts the frame on the beat itself
    assign start = beat_i.de & beat_i.sof;

    always_comb begin
        state_cur = start ? LINE_EVEN : state_q;
        col_cur   = start ? '0 : col_q;
        // first row pair of the frame, cleared after row 1
        first_cur = start | first_q;
    end

    // the column counter doubles as the line buffer address
    assign buf_addr_o = col_cur;
    assign buf_we_o   = beat_i.de;

    assign odd_row_o = (state_cur == LINE_ODD);
    assign odd_col_o = col_cur[0];

    assign blk_sof_o = beat_i.de & first_cur & odd_row_o & (col_cur == `BIN_ADDR_W'(1));
    assign blk_eol_o = beat_i.de & beat_i.eol & odd_row_o & odd_col_o;

    // --------------------
    // row and column state
    // --------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= LINE_IDLE;
            col_q   <= '0;
            first_q <= 1'b0;
        end else if (beat_i.de && state_cur != LINE_IDLE) begin
            if (beat_i.eol) begin
                col_q <= '0;
                // row parity flips at every line end
                if (state_cur == LINE_ODD) begin
                    state_q <= LINE_EVEN;
                    first_q <= 1'b0;
                end else begin
                    state_q <= LINE_ODD;
                    first_q <= first_cur;
                end
            end else begin
                col_q   <= col_cur + 1'b1;
                state_q <= state_cur;
                first_q <= first_cur;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/line_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module line_buffer (
    input  wire                    clk,
    input  wire                    we_i,
    input  wire [`BIN_ADDR_W-1:0]  addr_i,
    input  wire [`BIN_PIX_W-1:0]   wdata_i,
    output logic [`BIN_PIX_W-1:0]  rdata_o
);

    // --------------------
    // one line of pixels
    // --------------------

    logic [`BIN_PIX_W-1:0] mem [`BIN_LINE_MAX];

    // read-first port
    // the old word at the address is the pixel from the row above,
    // the new pixel replaces it at the same edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

/* hw/window_assembler.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module window_assembler import binning_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire video_beat_t      beat_i,
    input  wire [`BIN_PIX_W-1:0]  above_i,
    input  wire                   odd_row_i,
    input  wire                   odd_col_i,
    input  wire                   blk_sof_i,
    input  wire                   blk_eol_i,
    output bin_window_t           win_o
);

    // beat delayed to meet the buffer read data
    logic [`BIN_PIX_W-1:0] cur_d;
    logic                  de_d;
    logic                  close_d;
    logic                  sof_d;
    logic                  eol_d;

    // left neighbours, held across gaps
    logic [`BIN_PIX_W-1:0] left_cur_q;
    logic [`BIN_PIX_W-1:0] left_above_q;

    // registered window
    logic [`BIN_PIX_W-1:0] tl_q;
    logic [`BIN_PIX_W-1:0] tr_q;
    logic [`BIN_PIX_W-1:0] bl_q;
    logic [`BIN_PIX_W-1:0] br_q;
    logic                  valid_q;
    logic                  sof_q;
    logic                  eol_q;

    // --------------------
    // cycle 1 alignment
    // --------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_d    <= 1'b0;
            close_d <= 1'b0;
            sof_d   <= 1'b0;
            eol_d   <= 1'b0;
        end else begin
            de_d    <= beat_i.de;
            close_d <= beat_i.de & odd_row_i & odd_col_i;
            sof_d   <= blk_sof_i;
            eol_d   <= blk_eol_i;
        end
    end

    always_ff @(posedge clk) begin
        cur_d <= beat_i.pix;
    end

    // --------------------
    // cycle 2 window
    // --------------------

    always_ff @(posedge clk) begin
        if (de_d) begin
            left_cur_q   <= cur_d;
            left_above_q <= above_i;
            tl_q         <= left_above_q;
            tr_q         <= above_i;
            bl_q         <= left_cur_q;
            br_q         <= cur_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            sof_q   <= 1'b0;
            eol_q   <= 1'b0;
        end else begin
            valid_q <= close_d;
            sof_q   <= close_d & sof_d;
            eol_q   <= close_d & eol_d;
        end
    end

    always_comb begin
        win_o.top_left  = tl_q;
        win_o.top_right = tr_q;
        win_o.bot_left  = bl_q;
        win_o.bot_right = br_q;
        win_o.valid     = valid_q;
        win_o.sof       = sof_q;
        win_o.eol       = eol_q;
    end

endmodule

`default_nettype wire

/* hw/bin_average.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module bin_average import binning_pkg::*; (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire bin_window_t win_i,
    output video_beat_t      beat_o
);

    // stage 1, pair sums
    logic [`BIN_PIX_W:0]   sum_top_q;
    logic [`BIN_PIX_W:0]   sum_bot_q;
    logic                  s1_valid_q;
    logic                  s1_sof_q;
    logic                  s1_eol_q;

    // stage 2, block sum and output beat
    logic [`BIN_PIX_W+1:0] sum_all;
    logic [`BIN_PIX_W-1:0] out_pix_q;
    logic                  out_de_q;
    logic                  out_sof_q;
    logic                  out_eol_q;

    // --------------------
    // stage 1
    // --------------------

    // one extra bit per pair, no overflow at full scale
    always_ff @(posedge clk) begin
        sum_top_q <= {1'b0, win_i.top_left} + {1'b0, win_i.top_right};
        sum_bot_q <= {1'b0, win_i.bot_left} + {1'b0, win_i.bot_right};
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s1_sof_q   <= 1'b0;
            s1_eol_q   <= 1'b0;
        end else begin
            s1_valid_q <= win_i.valid;
            s1_sof_q   <= win_i.sof;
            s1_eol_q   <= win_i.eol;
        end
    end

    // --------------------
    // stage 2
    // --------------------

    assign sum_all = {1'b0, sum_top_q} + {1'b0, sum_bot_q};

    // divide by 4, truncating
    always_ff @(posedge clk) begin
        out_pix_q <= sum_all[`BIN_PIX_W+1:2];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_de_q  <= 1'b0;
            out_sof_q <= 1'b0;
            out_eol_q <= 1'b0;
        end else begin
            out_de_q  <= s1_valid_q;
            out_sof_q <= s1_valid_q & s1_sof_q;
            out_eol_q <= s1_valid_q & s1_eol_q;
        end
    end

    always_comb begin
        beat_o.pix = out_pix_q;
        beat_o.de  = out_de_q;
        beat_o.sof = out_sof_q;
        beat_o.eol = out_eol_q;
    end

endmodule

`default_nettype wire

/* hw/binning_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module binning_top import binning_pkg::*; (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              bypass_i,
    input  wire video_beat_t pix_i,
    output video_beat_t      pix_o
);

    logic [`BIN_ADDR_W-1:0]  buf_addr;
    logic                    buf_we;
    logic                    odd_row;
    logic                    odd_col;
    logic                    blk_sof;
    logic                    blk_eol;
    logic [`BIN_PIX_W-1:0]   above_pix;
    bin_window_t             window;
    video_beat_t             bin_beat;

    // bypass delay line, select bit travels with each beat
    video_beat_t             byp_beat_q [`BIN_LATENCY];
    logic [`BIN_LATENCY-1:0] byp_sel_q;

    // --------------------
    // binning path
    // --------------------

    line_timing line_timing_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .beat_i     (pix_i),
        .buf_addr_o (buf_addr),
        .buf_we_o   (buf_we),
        .odd_row_o  (odd_row),
        .odd_col_o  (odd_col),
        .blk_sof_o  (blk_sof),
        .blk_eol_o  (blk_eol)
    );

    line_buffer line_buffer_inst (
        .clk     (clk),
        .we_i    (buf_we),
        .addr_i  (buf_addr),
        .wdata_i (pix_i.pix),
        .rdata_o (above_pix)
    );

    window_assembler window_assembler_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .beat_i    (pix_i),
        .above_i   (above_pix),
        .odd_row_i (odd_row),
        .odd_col_i (odd_col),
        .blk_sof_i (blk_sof),
        .blk_eol_i (blk_eol),
        .win_o     (window)
    );

    bin_average bin_average_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .win_i   (window),
        .beat_o  (bin_beat)
    );

    // --------------------
    // bypass and output select
    // --------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BIN_LATENCY; i++) begin
                byp_beat_q[i] <= '0;
            end
            byp_sel_q <= '0;
        end else begin
            byp_beat_q[0] <= pix_i;
            for (int i = 1; i < `BIN_LATENCY; i++) begin
                byp_beat_q[i] <= byp_beat_q[i-1];
            end
            byp_sel_q <= {byp_sel_q[`BIN_LATENCY-2:0], bypass_i};
        end
    end

    // both sources are registered and cleared by reset
    assign pix_o = byp_sel_q[`BIN_LATENCY-1] ? byp_beat_q[`BIN_LATENCY-1] : bin_beat;

endmodule

`default_nettype wire

/* dv/binning_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module binning_checker import binning_pkg::*; (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              bypass_i,
    input  wire video_beat_t in_pix_i,
    input  wire video_beat_t dut_pix_i,
    input  wire              frame_done_i,
    input  wire [15:0]       test_id_i,
    input  wire [15:0]       exp_count_i,
    output int               err_cnt_o,
    output int               check_cnt_o,
    output int               fail_tests_o
);

    // model state rebuilt from each sof
    logic [`BIN_PIX_W-1:0] row_mem [`BIN_LINE_MAX];
    logic [`BIN_PIX_W-1:0] cur_left;
    bit                    active;
    int                    row;
    int                    col;

    // expected beats and the cycle each one is due
    video_beat_t           exp_q [$];
    int                    due_q [$];

    int                    cycle_cnt;
    int                    test_outs;
    int                    test_errs;

    task count_error();
        err_cnt_o = err_cnt_o + 1;
        test_errs = test_errs + 1;
    endtask

    // --------------------
    // output side
    // --------------------

    task compare_output();
        video_beat_t exp;
        int          due;
        while (due_q.size() > 0 && due_q[0] < cycle_cnt) begin
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            $display("t=%0t missing output beat with pix 0x%02h, due at cycle %0d, never came",
                     $time, exp.pix, due);
            count_error();
        end
        if (dut_pix_i.de) begin
            test_outs = test_outs + 1;
            if (due_q.size() == 0 || due_q[0] != cycle_cnt) begin
                $display("t=%0t unexpected output beat at cycle %0d, none was due",
                         $time, cycle_cnt);
                count_error();
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                check_cnt_o = check_cnt_o + 1;
                if (dut_pix_i.pix !== exp.pix) begin
                    $display("MISMATCH t=%0t pix_o.pix expected 0x%02h actual 0x%02h",
                             $time, exp.pix, dut_pix_i.pix);
                    count_error();
                end
                if (dut_pix_i.sof !== exp.sof) begin
                    $display("MISMATCH t=%0t pix_o.sof expected %0b actual %0b",
                             $time, exp.sof, dut_pix_i.sof);
                    count_error();
                end
                if (dut_pix_i.eol !== exp.eol) begin
                    $display("MISMATCH t=%0t pix_o.eol expected %0b actual %0b",
                             $time, exp.eol, dut_pix_i.eol);
                    count_error();
                end
            end
        end
    endtask

    // --------------------
    // reference model
    // --------------------

    task predict_beat();
        video_beat_t exp;
        int          sum;
        if (in_pix_i.de) begin
            if (in_pix_i.sof) begin
                active = 1'b1;
                row    = 0;
                col    = 0;
            end
            if (bypass_i) begin
                exp_q.push_back(in_pix_i);
                due_q.push_back(cycle_cnt + `BIN_LATENCY);
            end else if (active && (row % 2) == 1 && (col % 2) == 1) begin
                // block of the stored even row and the current odd row
                sum = int'(row_mem[col-1]) + int'(row_mem[col]) + int'(cur_left)
                    + int'(in_pix_i.pix);
                exp.pix = `BIN_PIX_W'(sum / 4);
                exp.de  = 1'b1;
                exp.sof = (row == 1 && col == 1);
                exp.eol = in_pix_i.eol;
                exp_q.push_back(exp);
                due_q.push_back(cycle_cnt + `BIN_LATENCY);
            end
            if (active) begin
                if ((row % 2) == 0) begin
                    row_mem[col] = in_pix_i.pix;
                end
                cur_left = in_pix_i.pix;
                if (in_pix_i.eol) begin
                    row = row + 1;
                    col = 0;
                end else begin
                    col = col + 1;
                end
            end
        end
    endtask

    task close_test();
        if (due_q.size() != 0) begin
            $display("t=%0t test %0d ended with %0d expected beats never produced",
                     $time, test_id_i, due_q.size());
            count_error();
            exp_q.delete();
            due_q.delete();
        end
        if (test_outs != int'(exp_count_i)) begin
            $display("MISMATCH t=%0t output_count expected %0d actual %0d",
                     $time, exp_count_i, test_outs);
            count_error();
        end
        $display("test %0d: %0d output beats, %0d errors, %s",
                 test_id_i, test_outs, test_errs, (test_errs == 0) ? "ok" : "fail");
        if (test_errs != 0) begin
            fail_tests_o = fail_tests_o + 1;
        end
        test_outs = 0;
        test_errs = 0;
    endtask

    // inputs change 1 ns after the rising edge and hold still at the falling edge
    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!rst_n_i) begin
            active = 1'b0;
            exp_q.delete();
            due_q.delete();
        end else begin
            compare_output();
            predict_beat();
            if (frame_done_i) begin
                close_test();
            end
        end
    end

endmodule

`default_nettype wire

/* dv/binning_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "binning_params.svh"

module binning_tb import binning_pkg::*; ();

    localparam int NUM_TESTS    = 9;
    localparam int FRAME_GAP    = 8;
    localparam int RESET_CYCLES = 5;

    // pixel patterns
    localparam int PAT_CONST = 0;
    localparam int PAT_RAMP  = 1;
    localparam int PAT_RAND  = 2;

    typedef struct packed {
        int         width;
        int         height;
        bit         bypass;
        int         gap;
        int         pattern;
        logic [7:0] value;
        int         exp_outs;
    } test_row_t;

    test_row_t   tests [NUM_TESTS];

    logic        clk = 1'b0;
    logic        rst_n;
    logic        bypass;
    video_beat_t pix_i;
    video_beat_t pix_o;
    logic        frame_done;
    logic [15:0] test_id;
    logic [15:0] exp_count;

    int          errors;
    int          checks;
    int          fail_tests;
    int          cycle_cnt = 0;
    int          timeout_cycles = 0;
    integer      seed = 6;

    always #2 clk = ~clk;

    binning_top binning_top_inst (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .bypass_i (bypass),
        .pix_i    (pix_i),
        .pix_o    (pix_o)
    );

    binning_checker checker_inst (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .bypass_i     (bypass),
        .in_pix_i     (pix_i),
        .dut_pix_i    (pix_o),
        .frame_done_i (frame_done),
        .test_id_i    (test_id),
        .exp_count_i  (exp_count),
        .err_cnt_o    (errors),
        .check_cnt_o  (checks),
        .fail_tests_o (fail_tests)
    );

    // --------------------
    // stimulus table
    // --------------------

    // width, height, bypass, gap mode, pattern, value, expected output beats
    task load_tests();
        tests[0] = '{8, 4, 1'b0, 0, PAT_CONST, 8'h5a, 8};
        tests[1] = '{16, 6, 1'b0, 0, PAT_RAMP, 8'h03, 24};
        tests[2] = '{12, 4, 1'b0, 1, PAT_RAND, 8'h00, 12};
        tests[3] = '{10, 6, 1'b0, 2, PAT_RAND, 8'h00, 15};
        tests[4] = '{8, 4, 1'b1, 2, PAT_RAND, 8'h00, 32};
        tests[5] = '{9, 5, 1'b0, 0, PAT_RAMP, 8'h11, 8};
        tests[6] = '{6, 4, 1'b0, 0, PAT_RAMP, 8'hf0, 6};
        tests[7] = '{8, 4, 1'b0, 0, PAT_CONST, 8'hff, 8};
        tests[8] = '{8, 4, 1'b0, 1, PAT_CONST, 8'hff, 8};
    endtask

    // twice the worst case beat count plus slack for reset and frame gaps
    function automatic int compute_timeout();
        int total;
        int factor;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            factor = (tests[t].gap == 0) ? 1 : (tests[t].gap == 1) ? 2 : 3;
            total  = total + tests[t].width * tests[t].height * factor;
        end
        return 2 * total + 100;
    endfunction

    // --------------------
    // drivers
    // --------------------

    task drive_idle();
        @(posedge clk);
        #1;
        pix_i = '0;
    endtask

    task drive_beat(input logic [7:0] p, input logic sof, input logic eol);
        @(posedge clk);
        #1;
        pix_i.pix = p;
        pix_i.de  = 1'b1;
        pix_i.sof = sof;
        pix_i.eol = eol;
    endtask

    task drive_frame(input int t);
        logic [7:0] p;
        int         gaps;
        for (int r = 0; r < tests[t].height; r++) begin
            for (int c = 0; c < tests[t].width; c++) begin
                // row and column steps of opposite parity leave a remainder of 2 in each block sum
                case (tests[t].pattern)
                    PAT_CONST: p = tests[t].value;
                    PAT_RAMP:  p = 8'(r * 17 + c * 6 + int'(tests[t].value));
                    default:   p = 8'($random(seed));
                endcase
                drive_beat(p, (r == 0 && c == 0), (c == tests[t].width - 1));
                case (tests[t].gap)
                    0:       gaps = 0;
                    1:       gaps = 1;
                    default: gaps = {$random(seed)} % 3;
                endcase
                repeat (gaps) drive_idle();
            end
        end
    endtask

    task run_test(input int t);
        @(posedge clk);
        #1;
        test_id   = 16'(t);
        exp_count = 16'(tests[t].exp_outs);
        bypass    = tests[t].bypass;
        drive_frame(t);
        // the gap also drains the pipeline
        repeat (FRAME_GAP) drive_idle();
        @(posedge clk);
        #1;
        frame_done = 1'b1;
        @(posedge clk);
        #1;
        frame_done = 1'b0;
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        rst_n      = 1'b0;
        bypass     = 1'b0;
        pix_i      = '0;
        frame_done = 1'b0;
        test_id    = '0;
        exp_count  = '0;
        load_tests();
        timeout_cycles = compute_timeout();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (2) @(posedge clk);
        $display("tests %0d, failed tests %0d, beats checked %0d, errors %0d",
                 NUM_TESTS, fail_tests, checks, errors);
        if (errors == 0 && fail_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_cycles > 0 && cycle_cnt > timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hw/binning_pkg.sv
hw/line_timing.sv
hw/line_buffer.sv
hw/window_assembler.sv
hw/bin_average.sv
hw/binning_top.sv
dv/binning_checker.sv
dv/binning_tb.sv

/* Bender.yml */
package:
  name: binning

sources:
  - include_dirs:
      - include
    files:
      - hw/binning_pkg.sv
      - hw/line_timing.sv
      - hw/line_buffer.sv
      - hw/window_assembler.sv
      - hw/bin_average.sv
      - hw/binning_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/binning_checker.sv
      - dv/binning_tb.sv
